//--- project.f
+incdir+rtl
+incdir+testbench
rtl/core_pkg.sv
rtl/frontend_stage.sv
rtl/instdec_stage.sv
rtl/issue_stage.sv
rtl/exe_stage.sv
rtl/commit_stage.sv
rtl/core.sv
testbench/tb_core.sv

//--- rtl/commit_stage.sv
`timescale 1ns/100ps

module commit_stage
	import core_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  commit_t result,
	output wb_t     wb,
	output commit_t trace
);

	// Retirement register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			trace <= '0;
		end else begin
			trace <= result;
		end
	end

	// Register write and scoreboard clear
	assign wb.we   = trace.valid & trace.we;
	assign wb.rd   = trace.rd;
	assign wb.data = trace.data;

endmodule

//--- rtl/core.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module core
	import core_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             run,
	input  logic             psel,	// APB program loader
	input  logic             penable,
	input  logic             pwrite,
	input  logic [`XLEN-1:0] paddr,
	input  logic [`XLEN-1:0] pwdata,
	output logic [`XLEN-1:0] prdata,
	output logic             pready,
	output logic             pslverr,
	output commit_t          trace	// One entry per retired instruction
);

	fetch_t    fetch;
	dec_t      dec;
	iss_t      iss;
	redirect_t redirect;	// Taken branch or jump, from execute
	commit_t   result;
	wb_t       wb;
	logic      stall;	// Scoreboard hazard, from issue

	frontend_stage frontend (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.stall    (stall),
		.redirect (redirect),
		.fetch    (fetch)
	);

	instdec_stage instdec (.clk(clk), .rst_n(rst_n), .fetch(fetch), .stall(stall),
		.redirect(redirect), .dec(dec));

	issue_stage issue (.clk(clk), .rst_n(rst_n), .dec(dec), .wb(wb), .redirect(redirect),
		.stall(stall), .iss(iss));

	exe_stage execute (.clk(clk), .rst_n(rst_n), .iss(iss), .redirect(redirect),
		.result(result));

	commit_stage commit (.clk(clk), .rst_n(rst_n), .result(result), .wb(wb), .trace(trace));

endmodule

//--- rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Integer register and datapath width
`define XLEN 32

// Instruction memory, in 32-bit words
`define IMEM_WORDS 256
`define IMEM_AW 8

// First fetch address after reset or while halted
`define RESET_PC 32'h0000_0000

`endif

//--- rtl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

	// RV32I major opcodes the core understands
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B	// LUI, operand B straight through
	} alu_op_e;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} fetch_t;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [4:0]       rs1;
		logic [4:0]       rs2;
		logic [4:0]       rd;
		logic             we;
		alu_op_e          alu_op;
		logic             use_imm;	// Operand B from imm
		logic [`XLEN-1:0] imm;
		logic             use_pc_a;	// Operand A from pc
		logic             is_branch;
		logic             bne;	// Inverted compare
		logic             is_jal;
	} dec_t;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] op_a;
		logic [`XLEN-1:0] op_b;
		logic [4:0]       rd;
		logic             we;
		alu_op_e          alu_op;
		logic [`XLEN-1:0] imm;	// Branch or jump offset
		logic             is_branch;
		logic             bne;
		logic             is_jal;
	} iss_t;

	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} redirect_t;

	// Retiring instruction, also the trace format
	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [4:0]       rd;
		logic             we;
		logic [`XLEN-1:0] data;
	} commit_t;

	typedef struct packed {
		logic             we;
		logic [4:0]       rd;
		logic [`XLEN-1:0] data;
	} wb_t;

endpackage

//--- rtl/exe_stage.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module exe_stage
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  iss_t      iss,
	output redirect_t redirect,
	output commit_t   result
);

	logic [`XLEN-1:0] alu_res;
	logic             eq;	// Branch compare
	logic [4:0]       shamt;

	assign shamt = iss.op_b[4:0];

	always_comb begin
		case (iss.alu_op)
			ALU_ADD:    alu_res = iss.op_a + iss.op_b;
			ALU_SUB:    alu_res = iss.op_a - iss.op_b;
			ALU_AND:    alu_res = iss.op_a & iss.op_b;
			ALU_OR:     alu_res = iss.op_a | iss.op_b;
			ALU_XOR:    alu_res = iss.op_a ^ iss.op_b;
			ALU_SLT:    alu_res = {31'b0, $signed(iss.op_a) < $signed(iss.op_b)};
			ALU_SLL:    alu_res = iss.op_a << shamt;
			ALU_SRL:    alu_res = iss.op_a >> shamt;	// Logical
			ALU_PASS_B: alu_res = iss.op_b;
			default:    alu_res = '0;
		endcase
	end

	assign eq = (iss.op_a == iss.op_b);

	// Resolved here, younger stages flush at the next edge
	assign redirect.taken  = iss.valid & (iss.is_jal | (iss.is_branch & (eq ^ iss.bne)));
	assign redirect.target = iss.pc + iss.imm;	// B or J offset

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			result.valid <= iss.valid;
			result.pc    <= iss.pc;
			result.rd    <= iss.rd;
			result.we    <= iss.we;
			result.data  <= iss.we ? alu_res : '0;	// Branches and NOPs report zero
		end
	end

endmodule

//--- rtl/frontend_stage.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module frontend_stage
	import core_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,	// Level, low holds the core at reset PC
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        stall,
	input  redirect_t   redirect,
	output fetch_t      fetch
);

	logic [`XLEN-1:0]    imem [`IMEM_WORDS];	// Program storage, word addressed
	logic [`XLEN-1:0]    pc;
	logic                apb_access;	// APB access phase
	logic                addr_err;
	logic [`IMEM_AW-1:0] apb_idx;
	logic [`IMEM_AW-1:0] pc_idx;

	assign apb_access = psel & penable;
	assign addr_err   = (paddr >= 32'(4 * `IMEM_WORDS));	// Past end of memory
	assign apb_idx    = paddr[`IMEM_AW+1:2];
	assign pc_idx     = pc[`IMEM_AW+1:2];

	// No wait states, every access finishes in its access phase
	assign pready  = 1'b1;
	// Program loads only allowed while halted
	assign pslverr = apb_access & (addr_err | run);
	assign prdata  = imem[apb_idx];

	// APB write port, erroring writes dropped
	always_ff @(posedge clk) begin
		if (apb_access && pwrite && !pslverr) begin
			imem[apb_idx] <= pwdata;
		end
	end

	// PC and fetch register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc    <= `RESET_PC;
			fetch <= '0;
		end else if (redirect.taken) begin	// Flush beats stall
			pc          <= redirect.target;
			fetch.valid <= 1'b0;
		end else if (!run) begin
			pc          <= `RESET_PC;	// Parked until run rises
			fetch.valid <= 1'b0;
		end else if (!stall) begin
			fetch.valid <= 1'b1;
			fetch.pc    <= pc;
			fetch.instr <= imem[pc_idx];
			pc          <= pc + 32'd4;	// Sequential
		end
		// Stall keeps both pc and fetch
	end

endmodule

//--- rtl/instdec_stage.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module instdec_stage
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  fetch_t    fetch,
	input  logic      stall,
	input  redirect_t redirect,
	output dec_t      dec
);

	logic [`XLEN-1:0] instr;
	opcode_e          opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	dec_t             dec_n;	// Next decode register value

	assign instr  = fetch.instr;
	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Sign extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec_n       = '0;	// Default is a NOP that still commits
		dec_n.valid = fetch.valid;
		dec_n.pc    = fetch.pc;
		dec_n.rd    = instr[11:7];
		case (opcode)
			OPC_OP: begin
				dec_n.rs1 = instr[19:15];
				dec_n.rs2 = instr[24:20];
				dec_n.we  = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec_n.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: dec_n.alu_op = ALU_SUB;
					{7'b0000000, 3'b001}: dec_n.alu_op = ALU_SLL;
					{7'b0000000, 3'b010}: dec_n.alu_op = ALU_SLT;
					{7'b0000000, 3'b100}: dec_n.alu_op = ALU_XOR;
					{7'b0000000, 3'b101}: dec_n.alu_op = ALU_SRL;
					{7'b0000000, 3'b110}: dec_n.alu_op = ALU_OR;
					{7'b0000000, 3'b111}: dec_n.alu_op = ALU_AND;
					default: begin	// SLTU, SRA, M extension
						dec_n.we  = 1'b0;
						dec_n.rs1 = '0;
						dec_n.rs2 = '0;
					end
				endcase
			end
			OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin	// ADDI only
					dec_n.rs1     = instr[19:15];
					dec_n.we      = 1'b1;
					dec_n.use_imm = 1'b1;
					dec_n.imm     = imm_i;
				end
			end
			OPC_LUI: begin
				dec_n.we      = 1'b1;
				dec_n.alu_op  = ALU_PASS_B;
				dec_n.use_imm = 1'b1;
				dec_n.imm     = imm_u;
			end
			OPC_AUIPC: begin
				dec_n.we       = 1'b1;
				dec_n.use_imm  = 1'b1;
				dec_n.use_pc_a = 1'b1;	// pc + imm_u
				dec_n.imm      = imm_u;
			end
			OPC_BRANCH: begin
				if (funct3[2:1] == 2'b00) begin	// BEQ and BNE
					dec_n.rs1       = instr[19:15];
					dec_n.rs2       = instr[24:20];
					dec_n.is_branch = 1'b1;
					dec_n.bne       = funct3[0];
					dec_n.imm       = imm_b;
				end
			end
			OPC_JAL: begin
				dec_n.we       = 1'b1;
				dec_n.use_pc_a = 1'b1;	// Link is pc + 4, constant added in issue
				dec_n.is_jal   = 1'b1;
				dec_n.imm      = imm_j;
			end
			default: ;
		endcase
		if (!dec_n.we) begin
			dec_n.rd = '0;	// Non-writing commits show rd zero
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec <= '0;
		end else if (redirect.taken) begin
			dec.valid <= 1'b0;	// Wrong path
		end else if (!stall) begin
			dec <= dec_n;
		end
	end

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module issue_stage
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dec_t      dec,
	input  wb_t       wb,
	input  redirect_t redirect,
	output logic      stall,
	output iss_t      iss
);

	logic [`XLEN-1:0] rf [1:31];	// x1..x31, x0 is hardwired
	logic [31:0]      busy;	// Pending write per register
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic             do_issue;
	logic [31:0]      set_mask;
	logic [31:0]      clr_mask;
	iss_t             iss_n;

	assign rs1_val = (dec.rs1 == 5'd0) ? '0 : rf[dec.rs1];
	assign rs2_val = (dec.rs2 == 5'd0) ? '0 : rf[dec.rs2];

	// Register write from commit
	always_ff @(posedge clk) begin
		if (wb.we && wb.rd != 5'd0) begin
			rf[wb.rd] <= wb.data;
		end
	end

	// RAW on either source, WAW on rd so one busy bit per register suffices
	assign stall    = dec.valid & (busy[dec.rs1] | busy[dec.rs2] | (dec.we & busy[dec.rd]));
	assign do_issue = dec.valid & ~stall & ~redirect.taken;

	assign set_mask = (do_issue && dec.we) ? (32'd1 << dec.rd) : '0;
	assign clr_mask = wb.we ? (32'd1 << wb.rd) : '0;

	// Flushed instructions never set a bit, only the one leaving this stage
	// could, and do_issue drops it on a redirect. Busy bits left are older.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			busy <= ((busy & ~clr_mask) | set_mask) & ~32'd1;	// x0 never busy
		end
	end

	// Operand select
	always_comb begin
		iss_n           = '0;
		iss_n.valid     = do_issue;	// Bubble on stall or flush
		iss_n.pc        = dec.pc;
		iss_n.op_a      = dec.use_pc_a ? dec.pc : rs1_val;
		if (dec.is_jal) begin
			iss_n.op_b = 32'd4;	// Link value
		end else begin
			iss_n.op_b = dec.use_imm ? dec.imm : rs2_val;
		end
		iss_n.rd        = dec.rd;
		iss_n.we        = dec.we;
		iss_n.alu_op    = dec.alu_op;
		iss_n.imm       = dec.imm;
		iss_n.is_branch = dec.is_branch;
		iss_n.bne       = dec.bne;
		iss_n.is_jal    = dec.is_jal;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iss <= '0;
		end else begin
			iss <= iss_n;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Verilator build and run of the core testbench
verilator --binary --timing -f project.f --top-module tb_core -Mdir obj_dir -o tb_core_sim \
	&& ./obj_dir/tb_core_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }

//--- testbench/tb_ref_model.svh
// Executes the instruction at model_pc and returns the commit it must produce
// Updates model_rf and model_pc of the including module
function automatic commit_t ref_step(input logic [31:0] ins);
	commit_t     c;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] off;	// Branch or jump offset
	logic [31:0] next_pc;
	a       = model_rf[ins[19:15]];
	b       = model_rf[ins[24:20]];
	next_pc = model_pc + 32'd4;
	c       = '0;
	c.valid = 1'b1;
	c.pc    = model_pc;
	c.we    = 1'b1;	// Cleared for branches and NOPs
	case (ins[6:0])
		7'b0110011: begin
			case ({ins[31:25], ins[14:12]})	// {funct7, funct3}
				10'h000: c.data = a + b;
				10'h100: c.data = a - b;
				10'h007: c.data = a & b;
				10'h006: c.data = a | b;
				10'h004: c.data = a ^ b;
				10'h002: c.data = {31'b0, $signed(a) < $signed(b)};
				10'h001: c.data = a << b[4:0];
				10'h005: c.data = a >> b[4:0];
				default: c.we = 1'b0;	// SLTU, SRA and others
			endcase
		end
		7'b0010011: begin
			c.we   = (ins[14:12] == 3'b000);	// ADDI only
			c.data = c.we ? a + {{20{ins[31]}}, ins[31:20]} : '0;
		end
		7'b0110111: c.data = {ins[31:12], 12'b0};	// LUI
		7'b0010111: c.data = model_pc + {ins[31:12], 12'b0};	// AUIPC
		7'b1100011: begin
			c.we = 1'b0;
			off  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			if (ins[14:13] == 2'b00 && ((a == b) != ins[12])) begin
				next_pc = model_pc + off;	// BEQ or BNE taken
			end
		end
		7'b1101111: begin
			off     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			c.data  = model_pc + 32'd4;	// Link
			next_pc = model_pc + off;
		end
		default: c.we = 1'b0;
	endcase
	if (c.we) begin
		c.rd = ins[11:7];
		if (c.rd != 5'd0) begin
			model_rf[c.rd] = c.data;	// x0 stays zero
		end
	end
	model_pc = next_pc;
	return c;
endfunction

// Walks prog_mem from the reset PC up to its jump to self, filling exp_q
task automatic fill_expected();
	logic [31:0] pc_before;
	exp_q.delete();
	model_pc = `RESET_PC;
	do begin
		pc_before = model_pc;
		exp_q.push_back(ref_step(prog_mem[model_pc[`IMEM_AW+1:2]]));
	end while (model_pc != pc_before);
endtask

//--- testbench/tb_core.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_core
	import core_pkg::*;
();

	localparam int n_instr     = 32 + 12 + 11 + 3 * 41 + 7;	// Commits over all programs
	localparam int n_apb       = n_instr + 40;	// Writes, read-back and probes
	localparam int cycle_limit = 8 * n_instr + 3 * n_apb;
	// funct3 per R-type selector, ADD SUB AND OR XOR SLT SLL SRL from bit 0
	localparam logic [23:0] r_funct3 = {3'd5, 3'd1, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	commit_t     trace;

	logic [31:0] prog_mem [`IMEM_WORDS];	// Mirror of the DUT memory
	logic [31:0] model_rf [32];
	logic [31:0] model_pc;
	logic [31:0] prog [$];	// Program being built
	commit_t     exp_q [$];	// Expected retirements, oldest first
	int          seed = 32'h1a1d_86f1;
	int          cycles;
	int          errors;
	int          errs_at_start;
	int          pass_count;
	int          fail_count;

	`include "tb_ref_model.svh"

	core core_inst (.*);

	always #20 clk = ~clk;	// 40 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Commits stopped before the expected trace was complete");
			$display("Testbench failed");
			$finish;
		end
	end

	// Each retirement against the oldest expected commit
	always @(negedge clk) begin
		if (trace.valid && exp_q.size() != 0) begin
			check_commit(trace, exp_q.pop_front());
		end
	end

	task automatic check_commit(input commit_t got, input commit_t exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: got pc %h rd %0d we %b data %h, exp pc %h rd %0d we %b data %h",
				$time, got.pc, got.rd, got.we, got.data, exp.pc, exp.rd, exp.we, exp.data);
		end
	endtask

	task automatic check_apb(input logic [31:0] got_data, input logic got_err,
			input logic [31:0] exp_data, input logic exp_err, input logic data_valid);
		if (got_err !== exp_err || (data_valid && got_data !== exp_data)) begin
			errors++;
			$display("error at %0t: APB prdata %h pslverr %b, expected prdata %h pslverr %b",
				$time, got_data, got_err, exp_data, exp_err);
		end
	endtask

	// Write data, or expected read data on a read
	task automatic apb_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
			input logic exp_err);
		@(posedge clk);
		#2;
		psel   = 1'b1;	// Setup phase
		pwrite = wr;
		paddr  = addr;
		pwdata = data;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (pready !== 1'b1) begin
			@(negedge clk);
		end
		check_apb(prdata, pslverr, data, exp_err, !wr && !exp_err);
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			apb_access(1'b1, 32'(4 * i), prog[i], 1'b0);
			prog_mem[i] = prog[i];
		end
	endtask

	// Runs until every expected commit has shown up, then halts and drains
	task automatic run_program();
		fill_expected();
		@(posedge clk);
		#2;
		run = 1'b1;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#2;
		run = 1'b0;
		repeat (8) @(posedge clk);	// Longer than the five stages
	endtask

	task automatic end_test(input string name);
		if (errors == errs_at_start) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, errors - errs_at_start);
		end
		errs_at_start = errors;
	endtask

	function automatic logic [31:0] r_type(input logic [2:0] sel, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		return {(sel == 3'd1) ? 7'h20 : 7'h00, rs2, rs1, r_funct3[3 * sel +: 3], rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, opc};	// LUI or AUIPC
	endfunction

	function automatic logic [31:0] branch(input logic bne, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// Branch and jump targets stay ahead, at most the final loop word 40
	function automatic logic [31:0] random_instr(input int idx);
		int         kind;
		int         fwd;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		kind = int'($unsigned($random(seed)) % 10);
		fwd  = 1 + int'($unsigned($random(seed)) % (40 - idx));
		rd   = 5'($random(seed));
		rs1  = 5'($random(seed));
		rs2  = 5'($random(seed));
		case (kind)
			0, 1, 2, 3: return r_type(3'($random(seed)), rd, rs1, rs2);
			4: return addi(rd, rs1, 12'($random(seed)));
			5: return u_type(OPC_LUI, rd, 20'($random(seed)));
			6: return u_type(OPC_AUIPC, rd, 20'($random(seed)));
			7: return branch(1'b0, rs1, rd[0] ? rs1 : rs2, 13'(4 * fwd));	// Half always equal
			8: return branch(1'b1, rs1, rs2, 13'(4 * fwd));
			default: return jal(rd, 21'(4 * fwd));
		endcase
	endfunction

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		run           = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		cycles        = 0;
		errors        = 0;
		errs_at_start = 0;
		pass_count    = 0;
		fail_count    = 0;
		foreach (model_rf[i]) begin
			model_rf[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Program that sets x1 to x31, doubles as the load test
		for (int i = 1; i < 32; i++) begin
			prog.push_back(addi(5'(i), 5'd0, 12'($random(seed))));
		end
		prog.push_back(jal(5'd0, 21'd0));
		load_program();
		foreach (prog[i]) begin
			apb_access(1'b0, 32'(4 * i), prog[i], 1'b0);
		end
		end_test("apb write and read-back");

		// Past the end aliases word 0 if not dropped
		apb_access(1'b1, 32'(4 * `IMEM_WORDS), 32'hdead_beef, 1'b1);
		apb_access(1'b0, 32'(4 * `IMEM_WORDS), 32'h0, 1'b1);
		fork
			run_program();
			apb_access(1'b1, 32'h0, ~prog_mem[0], 1'b1);	// While running
		join
		apb_access(1'b0, 32'h0, prog_mem[0], 1'b0);
		end_test("apb errors");

		prog.delete();
		prog.push_back(u_type(OPC_LUI, 5'd5, 20'h12345));
		prog.push_back(addi(5'd5, 5'd5, 12'h678));
		prog.push_back(r_type(3'd0, 5'd6, 5'd5, 5'd5));	// ADD
		prog.push_back(r_type(3'd1, 5'd7, 5'd6, 5'd5));	// SUB
		prog.push_back(u_type(OPC_AUIPC, 5'd8, 20'h00001));
		prog.push_back(r_type(3'd4, 5'd9, 5'd8, 5'd7));	// XOR
		prog.push_back(r_type(3'd6, 5'd10, 5'd9, 5'd1));	// SLL by x1
		prog.push_back(r_type(3'd7, 5'd11, 5'd10, 5'd2));	// SRL by x2
		prog.push_back(r_type(3'd5, 5'd12, 5'd11, 5'd9));	// SLT
		prog.push_back(r_type(3'd2, 5'd13, 5'd12, 5'd11));	// AND
		prog.push_back(r_type(3'd3, 5'd14, 5'd13, 5'd10));	// OR
		prog.push_back(jal(5'd0, 21'd0));
		load_program();
		run_program();
		end_test("dependent alu chain");

		prog.delete();
		prog.push_back(addi(5'd1, 5'd0, 12'd5));
		prog.push_back(branch(1'b0, 5'd1, 5'd1, 13'd8));	// BEQ taken
		prog.push_back(addi(5'd3, 5'd0, 12'd99));	// Wrong path
		prog.push_back(branch(1'b1, 5'd1, 5'd1, 13'd8));	// BNE not taken
		prog.push_back(branch(1'b1, 5'd1, 5'd0, 13'd8));	// BNE taken
		prog.push_back(addi(5'd3, 5'd0, 12'd98));	// Wrong path
		prog.push_back(branch(1'b0, 5'd1, 5'd0, 13'd8));	// BEQ not taken
		prog.push_back(jal(5'd15, 21'd8));
		prog.push_back(addi(5'd3, 5'd0, 12'd97));	// Wrong path
		prog.push_back(r_type(3'd0, 5'd16, 5'd15, 5'd1));	// Reads the link
		prog.push_back(jal(5'd0, 21'd0));
		load_program();
		run_program();
		end_test("control flow");

		for (int p = 0; p < 3; p++) begin
			prog.delete();
			for (int i = 0; i < 40; i++) begin
				prog.push_back(random_instr(i));
			end
			prog.push_back(jal(5'd0, 21'd0));
			load_program();
			run_program();
		end
		end_test("random programs");

		prog.delete();
		prog.push_back(addi(5'd0, 5'd0, 12'h07b));	// Commits its value anyway
		prog.push_back(r_type(3'd0, 5'd17, 5'd0, 5'd0));
		prog.push_back(u_type(OPC_LUI, 5'd0, 20'habcde));
		prog.push_back(addi(5'd18, 5'd0, 12'h007));
		prog.push_back(r_type(3'd0, 5'd0, 5'd18, 5'd18));
		prog.push_back(r_type(3'd3, 5'd19, 5'd0, 5'd18));	// OR with x0
		prog.push_back(jal(5'd0, 21'd0));
		load_program();
		run_program();
		end_test("x0 register");

		$display("Tests ok %0d, tests with errors %0d, errors %0d", pass_count, fail_count,
			errors);
		if (fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
